// File: Makefile
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch -f list.f -Mdir obj_dir

run: compile
	./obj_dir/Vtb_fetch | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: bench/fetch_properties.sv
// bound assertions on request hold, if/id reset state and if/id stall
`timescale 1ns/1ps

module fetch_properties (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 req_i,
  input logic                 pc_set_i,
  input logic                 id_ready_i,
  input logic                 instr_valid_id_o,
  input fetch_pkg::ibus_req_t ibus_req_o,
  input fetch_pkg::ibus_rsp_t ibus_rsp_i,
  input fetch_pkg::id_instr_t id_instr_o
);

  // a waiting request keeps its address, a redirect starts a new one
  addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (ibus_req_o.req && !ibus_rsp_i.gnt && req_i) |=>
      (pc_set_i || (ibus_req_o.req && $stable(ibus_req_o.addr))))
    else $error("bus request changed before grant");

  valid_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !instr_valid_id_o)
    else $error("instr_valid_id_o high right after reset");

  // id stall freezes the if/id register
  stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (!id_ready_i && instr_valid_id_o) |=> $stable(id_instr_o))
    else $error("if/id register changed while id stalled");

endmodule

bind if_stage fetch_properties i_props (.*);

// File: bench/tb_clock_gen.sv
// testbench clock and power-on reset source
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1;  // released after three rising edges
  end

endmodule

// File: bench/tb_fetch.sv
// fetch testbench: memory responder, random stimulus, pc and rvc model, checks and summary
`timescale 1ns/1ps

module tb_fetch;

  logic                 clk, rst_n;
  fetch_pkg::redirect_t redirect = '0;
  fetch_pkg::targets_t  targets = '0;
  fetch_pkg::trap_cfg_t trap_cfg = '0;
  logic                 req = 1'b0, halt = 1'b0, id_ready = 1'b0, clear_valid = 1'b0;
  fetch_pkg::ibus_req_t ibus_req;
  fetch_pkg::ibus_rsp_t ibus_rsp = '0;
  fetch_pkg::id_instr_t id_instr;
  logic                 instr_valid;
  logic [31:0]          pc_if;

  string       test_name [5] = '{"boot", "expansion", "redirect", "backpressure", "clear"};
  int          n_checks [5] = '{default: 0};
  int          n_errors [5] = '{default: 0};
  int          cur_test = 0;
  int          n_seen = 0;     // instructions seen in id
  bit          form_seen [9];  // 1..7 supported forms, 8 illegal
  bit          mon_en = 1'b1;
  bit          stuck = 1'b0;
  logic [31:0] exp_pc, last_pc;
  logic [31:0] pc_if_prev;     // pc on offer in the cycle of the last load
  int          rq_due [$];
  logic [31:0] rq_addr [$];
  int          cyc, last_due;

  tb_clock_gen i_clk (.clk_o(clk), .rst_n_o(rst_n));

  fetch_top i_dut (
    .clk (clk), .rst_n (rst_n),
    .redirect_i (redirect), .targets_i (targets), .trap_cfg_i (trap_cfg),
    .req_i (req), .halt_i (halt), .id_ready_i (id_ready), .clear_valid_i (clear_valid),
    .ibus_req_o (ibus_req), .ibus_rsp_i (ibus_rsp),
    .id_instr_o (id_instr), .instr_valid_id_o (instr_valid), .pc_if_o (pc_if)
  );

  //////////////////////////////
  // model
  //////////////////////////////

  // memory image, kind picked from address bits
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] h;
    h = (addr * 32'h9e3779b1) ^ (addr >> 11);
    case (addr[5:2] ^ addr[9:6])
      4'd0:    mem_word = {h[31:16], 3'b010, h[12:2], 2'b00};  // c.lw
      4'd1:    mem_word = {h[31:16], 3'b110, h[12:2], 2'b00};  // c.sw
      4'd2:    mem_word = {h[31:16], 3'b000, h[12:2], 2'b01};  // c.addi
      4'd3:    mem_word = {h[31:16], 3'b010, h[12:2], 2'b01};  // c.li
      4'd4:    mem_word = {h[31:16], 3'b101, h[12:2], 2'b01};  // c.j
      4'd5:    mem_word = {h[31:16], 3'b100, 1'b0, h[11:7], h[6:3], 1'b1, 2'b10};  // c.mv
      4'd6:    mem_word = {h[31:16], 3'b100, 1'b1, h[11:7], h[6:3], 1'b1, 2'b10};  // c.add
      4'd7:    mem_word = {h[31:16], 3'b000, h[12:2], 2'b00};  // addi4spn
      4'd8:    mem_word = {h[31:16], 3'b011, h[12:2], 2'b01};  // lui
      4'd9:    mem_word = {h[31:16], 3'b000, h[12:2], 2'b10};  // slli
      4'd10:   mem_word = {h[31:16], 3'b100, 1'b0, h[11:7], 5'd0, 2'b10};  // jr
      default: mem_word = {h[31:2], 2'b11};
    endcase
  endfunction

  function automatic void expand(input logic [31:0] w, output logic [31:0] ins,
                                 output logic comp, output logic ill, output int form);
    logic [11:0] imm;
    logic [20:0] off;
    logic [4:0]  rd, rs2, rdp, rs1p;
    rd   = w[11:7];
    rs2  = w[6:2];
    rdp  = 5'd8 + {2'b00, w[4:2]};   // rd' and rs2'
    rs1p = 5'd8 + {2'b00, w[9:7]};
    imm  = {5'b0, w[5], w[12:10], w[6], 2'b00};  // lw/sw word offset
    off  = '0;
    ins  = w;
    comp = (w[1:0] != 2'b11);
    ill  = comp;
    form = comp ? 8 : 0;
    if (comp) begin
      case ({w[1:0], w[15:13]})
        5'b00_010: begin
          ins  = {imm, rs1p, 3'b010, rdp, 7'b0000011};
          form = 1;
        end
        5'b00_110: begin
          ins  = {imm[11:5], rdp, rs1p, 3'b010, imm[4:0], 7'b0100011};
          form = 2;
        end
        5'b01_000: begin
          ins  = {{6{w[12]}}, w[12], w[6:2], rd, 3'b000, rd, 7'b0010011};
          form = 3;
        end
        5'b01_010: begin
          ins  = {{6{w[12]}}, w[12], w[6:2], 5'd0, 3'b000, rd, 7'b0010011};
          form = 4;
        end
        5'b01_101: begin
          off[20:11] = {10{w[12]}};
          off[10]    = w[8];
          off[9:8]   = w[10:9];
          off[7]     = w[6];
          off[6]     = w[7];
          off[5]     = w[2];
          off[4]     = w[11];
          off[3:1]   = w[5:3];
          ins  = {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
          form = 5;
        end
        5'b10_100: begin
          if (rs2 != 5'd0) begin
            ins  = {7'b0, rs2, (w[12] ? rd : 5'd0), 3'b000, rd, 7'b0110011};
            form = w[12] ? 7 : 6;
          end
        end
        default: ;
      endcase
      ill = (form == 8);
    end
  endfunction

  // redirect address from the currently driven selectors
  function automatic logic [31:0] redirect_target(input logic [31:0] id_pc);
    logic [23:0] base;
    logic [5:0]  cause;
    logic [32:0] vec;
    logic [31:0] exc;
    base  = (redirect.trap_sel == fetch_pkg::TRAP_USER) ? trap_cfg.u_base : trap_cfg.m_base;
    cause = (redirect.trap_sel == fetch_pkg::TRAP_USER) ? redirect.u_vec : redirect.m_vec;
    vec   = {base, 1'b0, cause, 2'b00};
    case (redirect.exc_pc_mux)
      fetch_pkg::EXC_PC_IRQ: exc = vec[31:0];
      fetch_pkg::EXC_PC_DBG: exc = {trap_cfg.dm_halt, 2'b00};
      default:               exc = {base, 8'h00};
    endcase
    case (redirect.pc_mux)
      fetch_pkg::PC_JUMP:      redirect_target = targets.jump_id;
      fetch_pkg::PC_BRANCH:    redirect_target = targets.jump_ex;
      fetch_pkg::PC_EXCEPTION: redirect_target = exc;
      fetch_pkg::PC_MRET:      redirect_target = targets.mepc;
      fetch_pkg::PC_URET:      redirect_target = targets.uepc;
      fetch_pkg::PC_DRET:      redirect_target = targets.depc;
      fetch_pkg::PC_FENCEI:    redirect_target = id_pc + 32'd4;
      default:                 redirect_target = {targets.boot, 1'b0};
    endcase
  endfunction

  task automatic fail_value(input string what, input logic [31:0] expv, input logic [31:0] actv);
    $display("Fail %s %s expected 0x%08h actual 0x%08h", test_name[cur_test], what, expv, actv);
    n_errors[cur_test]++;
  endtask

  //////////////////////////////
  // memory responder
  //////////////////////////////

  always @(posedge clk) begin
    int due;
    if (!rst_n) begin
      rq_due.delete();
      rq_addr.delete();
      cyc      = 0;
      last_due = 0;
      ibus_rsp <= '0;
    end else begin
      cyc = cyc + 1;
      if (ibus_req.req && ibus_rsp.gnt) begin
        due = cyc + 1 + int'($urandom % 4);   // 1 to 4 cycles, kept in order
        if (due <= last_due) due = last_due + 1;
        rq_due.push_back(due);
        rq_addr.push_back(ibus_req.addr);
        last_due = due;
      end
      n_checks[cur_test]++;
      if (rq_due.size() > 2) fail_value("outstanding requests", 32'd2, rq_due.size());
      ibus_rsp.gnt <= (($urandom % 4) != 0);
      if (rq_due.size() != 0 && rq_due[0] <= cyc + 1) begin
        ibus_rsp.rvalid <= 1'b1;
        ibus_rsp.rdata  <= mem_word(rq_addr[0]);
        void'(rq_due.pop_front());
        void'(rq_addr.pop_front());
      end else begin
        ibus_rsp.rvalid <= 1'b0;
        ibus_rsp.rdata  <= '0;
      end
    end
  end

  //////////////////////////////
  // id side monitor
  //////////////////////////////

  // clear_valid stays high here, so valid marks one fresh load
  always @(posedge clk) begin
    logic [31:0] e_ins;
    logic        e_comp, e_ill;
    int          form;
    if (!rst_n) begin
      exp_pc = {targets.boot, 1'b0};
    end else if (mon_en) begin
      if (instr_valid) begin
        expand(mem_word(exp_pc), e_ins, e_comp, e_ill, form);
        n_checks[cur_test] += 5;
        if (id_instr.pc !== exp_pc) fail_value("pc", exp_pc, id_instr.pc);
        if (pc_if_prev !== exp_pc) fail_value("pc_if", exp_pc, pc_if_prev);
        if (!e_ill && id_instr.instr !== e_ins) fail_value("instr", e_ins, id_instr.instr);
        if (id_instr.is_compressed !== e_comp) begin
          fail_value("is_compressed", e_comp, id_instr.is_compressed);
        end
        if (id_instr.illegal_c !== e_ill) fail_value("illegal_c", e_ill, id_instr.illegal_c);
        form_seen[form] = 1'b1;
        last_pc = exp_pc;
        exp_pc  = exp_pc + 32'd4;  // sequential fetch
        n_seen <= n_seen + 1;
      end
      if (redirect.pc_set) exp_pc = redirect_target(last_pc);
    end
    pc_if_prev = pc_if;
  end

  always @(posedge clk) begin
    if (stuck) begin
      $display("Regression failed");
      $finish;
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic hang_up();
    stuck = 1'b1;
    wait (stuck == 1'b0);  // watchdog ends the run
  endtask

  task automatic wait_instrs(input int n, input int limit);
    int target;
    int k;
    target = n_seen + n;
    k = 0;
    while (n_seen < target) begin
      @(posedge clk);
      k++;
      if (k > limit) begin
        $display("%s: no instruction reached id before the timeout", test_name[cur_test]);
        hang_up();
      end
    end
  endtask

  task automatic finish_test();
    $display("test %-12s %0d checks %0d errors", test_name[cur_test],
             n_checks[cur_test], n_errors[cur_test]);
    cur_test++;
  endtask

  initial begin
    int tot_checks;
    int tot_errors;
    int k;
    void'($urandom(32'hb016));
    targets.boot = 31'h0000_0400;  // boot pc 0x800
    k = 0;
    while (!rst_n) begin
      @(posedge clk);
      k++;
      if (k > 20) begin
        $display("reset never released");
        hang_up();
      end
    end
    @(posedge clk);
    req         <= 1'b1;
    id_ready    <= 1'b1;
    clear_valid <= 1'b1;
    wait_instrs(20, 500);
    finish_test();

    wait_instrs(300, 5000);
    for (int f = 1; f <= 8; f++) begin
      n_checks[cur_test]++;
      if (!form_seen[f]) begin
        $display("Fail expansion: form %0d never reached id", f);
        n_errors[cur_test]++;
      end
    end
    finish_test();

    repeat (40) begin
      repeat ($urandom % 6) @(posedge clk);
      redirect.pc_set     <= 1'b1;
      redirect.pc_mux     <= fetch_pkg::pc_mux_e'(3'($urandom % 8));
      redirect.exc_pc_mux <= fetch_pkg::exc_pc_e'(2'($urandom % 3));
      redirect.trap_sel   <= fetch_pkg::trap_sel_e'(2'($urandom % 2));
      redirect.m_vec      <= 6'($urandom);
      redirect.u_vec      <= 6'($urandom);
      targets.jump_id     <= $urandom & 32'hffff_fffc;
      targets.jump_ex     <= $urandom & 32'hffff_fffc;
      targets.mepc        <= $urandom & 32'hffff_fffc;
      targets.uepc        <= $urandom & 32'hffff_fffc;
      targets.depc        <= $urandom & 32'hffff_fffc;
      trap_cfg.m_base     <= 24'($urandom);
      trap_cfg.u_base     <= 24'($urandom);
      trap_cfg.dm_halt    <= 30'($urandom);
      @(posedge clk);
      redirect.pc_set <= 1'b0;
      wait_instrs(3, 200);
    end
    finish_test();

    repeat (400) begin
      @(posedge clk);
      id_ready <= (($urandom % 10) < 6);
      halt     <= (($urandom % 10) < 2);
    end
    id_ready <= 1'b1;
    halt     <= 1'b0;
    wait_instrs(4, 200);
    finish_test();

    // stall with clear, valid must drop
    id_ready <= 1'b0;
    repeat (3) @(posedge clk);
    n_checks[cur_test]++;
    if (instr_valid !== 1'b0) fail_value("instr_valid_id_o after clear", 32'd0, instr_valid);
    mon_en      <= 1'b0;
    clear_valid <= 1'b0;
    id_ready    <= 1'b1;
    k = 0;
    while (instr_valid !== 1'b1) begin
      @(posedge clk);
      k++;
      if (k > 50) begin
        $display("clear: no instruction moved into if/id");
        hang_up();
      end
    end
    id_ready <= 1'b0;
    repeat (3) @(posedge clk);
    n_checks[cur_test]++;
    if (instr_valid !== 1'b1) fail_value("instr_valid_id_o held", 32'd1, instr_valid);
    clear_valid <= 1'b1;
    repeat (2) @(posedge clk);
    n_checks[cur_test]++;
    if (instr_valid !== 1'b0) fail_value("instr_valid_id_o cleared", 32'd0, instr_valid);
    finish_test();

    tot_checks = 0;
    tot_errors = 0;
    for (int t = 0; t < 5; t++) begin
      tot_checks += n_checks[t];
      tot_errors += n_errors[t];
    end
    $display("summary: %0d tests %0d checks %0d errors", 5, tot_checks, tot_errors);
    if (tot_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: hw/compressed_decoder.sv
// expander for the supported rvc subset, with illegal flag for all other compressed words
`timescale 1ns/1ps

module compressed_decoder (
  input  rvc_pkg::fetch_word_u instr_i,
  output logic [31:0]          instr_o,
  output logic                 is_compressed_o,
  output logic                 illegal_o
);

  logic [15:0] c;   // compressed halfword, raw bits for immediates

  assign c = instr_i.comp[15:0];

  assign is_compressed_o = (instr_i.full.opcode[1:0] != rvc_pkg::Q3);

  always_comb begin
    instr_o   = instr_i;  // full size passes through
    illegal_o = 1'b0;

    unique case (instr_i.comp.quadrant)
      //////////////////////////////
      rvc_pkg::Q0: begin
        case (instr_i.comp.funct3)
          rvc_pkg::C_F3_LW: begin
            // lw rd', uimm(rs1')
            instr_o = {5'b0, c[5], c[12:10], c[6], 2'b00, 2'b01, c[9:7],
                       rvc_pkg::F3_WORD, 2'b01, c[4:2], rvc_pkg::OPC_LOAD};
          end
          rvc_pkg::C_F3_SW: begin
            // sw rs2', uimm(rs1')
            instr_o = {5'b0, c[5], c[12], 2'b01, c[4:2], 2'b01, c[9:7],
                       rvc_pkg::F3_WORD, c[11:10], c[6], 2'b00, rvc_pkg::OPC_STORE};
          end
          default: illegal_o = 1'b1;
        endcase
      end

      //////////////////////////////
      rvc_pkg::Q1: begin
        case (instr_i.comp.funct3)
          rvc_pkg::C_F3_ADDI: begin
            // addi rd, rd, simm6
            instr_o = {{6{c[12]}}, c[12], c[6:2], instr_i.comp.rd_rs1, rvc_pkg::F3_ADD,
                       instr_i.comp.rd_rs1, rvc_pkg::OPC_OP_IMM};
          end
          rvc_pkg::C_F3_LI: begin
            // addi rd, x0, simm6
            instr_o = {{6{c[12]}}, c[12], c[6:2], 5'd0, rvc_pkg::F3_ADD,
                       instr_i.comp.rd_rs1, rvc_pkg::OPC_OP_IMM};
          end
          rvc_pkg::C_F3_J: begin
            // jal x0, offset, bits land in jal immediate order
            instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                       {9{c[12]}}, 5'd0, rvc_pkg::OPC_JAL};
          end
          default: illegal_o = 1'b1;
        endcase
      end

      //////////////////////////////
      rvc_pkg::Q2: begin
        if (instr_i.comp.funct3 == rvc_pkg::C_F3_MV_ADD && instr_i.comp.rs2 != 5'd0) begin
          if (instr_i.comp.b12) begin
            // add rd, rd, rs2
            instr_o = {7'b0, instr_i.comp.rs2, instr_i.comp.rd_rs1, rvc_pkg::F3_ADD,
                       instr_i.comp.rd_rs1, rvc_pkg::OPC_OP};
          end else begin
            // mv is add rd, x0, rs2
            instr_o = {7'b0, instr_i.comp.rs2, 5'd0, rvc_pkg::F3_ADD,
                       instr_i.comp.rd_rs1, rvc_pkg::OPC_OP};
          end
        end else begin
          illegal_o = 1'b1;  // jr, jalr, ebreak and the rest of q2
        end
      end

      default: ;  // q3, nothing to expand
    endcase
  end

endmodule

// File: hw/fetch_pkg.sv
// fetch stage encodings: pc and exception selectors, trap select, redirect, bus and if/id structs
package fetch_pkg;

  // total of queued words plus outstanding bus requests
  localparam int unsigned FIFO_DEPTH = 2;

  //////////////////////////////
  // selectors
  //////////////////////////////

  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,  // target from id
    PC_BRANCH    = 3'd2,  // target from ex
    PC_EXCEPTION = 3'd3,
    PC_MRET      = 3'd4,
    PC_URET      = 3'd5,
    PC_DRET      = 3'd6,
    PC_FENCEI    = 3'd7   // refetch after fence.i
  } pc_mux_e;

  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'd0,
    EXC_PC_IRQ       = 2'd1,  // vectored
    EXC_PC_DBG       = 2'd2
  } exc_pc_e;

  typedef enum logic [1:0] {
    TRAP_MACHINE = 2'd0,
    TRAP_USER    = 2'd1
  } trap_sel_e;

  //////////////////////////////
  // bundles
  //////////////////////////////

  typedef struct packed {
    logic      pc_set;      // redirect request
    pc_mux_e   pc_mux;
    exc_pc_e   exc_pc_mux;
    trap_sel_e trap_sel;
    logic [5:0] m_vec;      // machine irq cause
    logic [5:0] u_vec;      // user irq cause
  } redirect_t;

  typedef struct packed {
    logic [31:0] jump_id;
    logic [31:0] jump_ex;
    logic [31:0] mepc;
    logic [31:0] uepc;
    logic [31:0] depc;
    logic [30:0] boot;      // halfword address
  } targets_t;

  typedef struct packed {
    logic [23:0] m_base;
    logic [23:0] u_base;
    logic [29:0] dm_halt;   // word address of debug entry
  } trap_cfg_t;

  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } ibus_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } ibus_rsp_t;

  typedef struct packed {
    logic [31:0] instr;          // expanded instruction
    logic [31:0] pc;
    logic        is_compressed;
    logic        illegal_c;
  } id_instr_t;

endpackage

// File: hw/fetch_top.sv
// fetch unit top with redirect target mux and fetch stage
`timescale 1ns/1ps

module fetch_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  fetch_pkg::redirect_t redirect_i,
  input  fetch_pkg::targets_t  targets_i,
  input  fetch_pkg::trap_cfg_t trap_cfg_i,
  input  logic                 req_i,
  input  logic                 halt_i,
  input  logic                 id_ready_i,
  input  logic                 clear_valid_i,
  output fetch_pkg::ibus_req_t ibus_req_o,
  input  fetch_pkg::ibus_rsp_t ibus_rsp_i,
  output fetch_pkg::id_instr_t id_instr_o,
  output logic                 instr_valid_id_o,
  output logic [31:0]          pc_if_o
);

  logic [31:0] fetch_addr_n;  // redirect target, same cycle

  pc_target_mux i_pc_mux (
    .redirect_i     (redirect_i),
    .targets_i      (targets_i),
    .trap_cfg_i     (trap_cfg_i),
    .pc_id_i        (id_instr_o.pc),  // fence.i restarts after the id instruction
    .fetch_addr_n_o (fetch_addr_n)
  );

  if_stage i_if_stage (
    .clk              (clk),
    .rst_n            (rst_n),
    .req_i            (req_i),
    .pc_set_i         (redirect_i.pc_set),
    .fetch_addr_n_i   (fetch_addr_n),
    .halt_i           (halt_i),
    .id_ready_i       (id_ready_i),
    .clear_valid_i    (clear_valid_i),
    .ibus_req_o       (ibus_req_o),
    .ibus_rsp_i       (ibus_rsp_i),
    .id_instr_o       (id_instr_o),
    .instr_valid_id_o (instr_valid_id_o),
    .pc_if_o          (pc_if_o)
  );

endmodule

// File: hw/if_stage.sv
// fetch stage with redirect fsm, prefetch queue, rvc expander and if/id register
`timescale 1ns/1ps

module if_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_i,
  input  logic                 pc_set_i,
  input  logic [31:0]          fetch_addr_n_i,    // redirect target
  input  logic                 halt_i,
  input  logic                 id_ready_i,
  input  logic                 clear_valid_i,
  output fetch_pkg::ibus_req_t ibus_req_o,
  input  fetch_pkg::ibus_rsp_t ibus_rsp_i,
  output fetch_pkg::id_instr_t id_instr_o,
  output logic                 instr_valid_id_o,
  output logic [31:0]          pc_if_o
);

  typedef enum logic [0:0] {IDLE, WAIT} state_e;

  state_e      state_q, state_n;
  logic        branch_req;    // restart prefetch
  logic        fetch_valid, fetch_ready;
  logic [31:0] fetch_rdata, fetch_addr;
  logic        valid;         // instruction on offer to id
  logic        if_valid;      // instruction moves into if/id
  logic [31:0] instr_exp;
  logic        is_comp, illegal_c;

  prefetch_buffer i_prefetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .branch_i      (branch_req),
    .branch_addr_i ({fetch_addr_n_i[31:1], 1'b0}),  // halfword aligned
    .fetch_ready_i (fetch_ready),
    .fetch_valid_o (fetch_valid),
    .fetch_rdata_o (fetch_rdata),
    .fetch_addr_o  (fetch_addr),
    .ibus_req_o    (ibus_req_o),
    .ibus_rsp_i    (ibus_rsp_i)
  );

  compressed_decoder i_decoder (
    .instr_i         (rvc_pkg::fetch_word_u'(fetch_rdata)),
    .instr_o         (instr_exp),
    .is_compressed_o (is_comp),
    .illegal_o       (illegal_c)
  );

  //////////////////////////////
  // redirect fsm
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) state_q <= IDLE;
    else        state_q <= state_n;
  end

  always_comb begin
    state_n    = state_q;
    branch_req = 1'b0;
    valid      = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (req_i) begin
          branch_req = 1'b1;  // first fetch goes to the selected target
          state_n    = WAIT;
        end
      end
      WAIT: valid = fetch_valid;
      default: state_n = IDLE;
    endcase

    // redirect overrides whatever is on offer
    if (pc_set_i) begin
      valid      = 1'b0;
      branch_req = 1'b1;
      state_n    = WAIT;
    end

    if_valid    = valid & id_ready_i & ~halt_i;
    fetch_ready = if_valid;  // pop exactly what moves in
  end

  assign pc_if_o = fetch_addr;

  //////////////////////////////
  // if/id register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_id_o <= 1'b0;
    end else if (if_valid) begin
      instr_valid_id_o <= 1'b1;
    end else if (clear_valid_i) begin
      instr_valid_id_o <= 1'b0;  // id consumed it, nothing new behind
    end
  end

  // frozen while id stalls
  always_ff @(posedge clk) begin
    if (if_valid) begin
      id_instr_o.instr         <= instr_exp;
      id_instr_o.pc            <= fetch_addr;
      id_instr_o.is_compressed <= is_comp;
      id_instr_o.illegal_c     <= illegal_c;
    end
  end

endmodule

// File: hw/pc_target_mux.sv
// redirect target selection with exception, vectored interrupt and debug entry addresses
`timescale 1ns/1ps

module pc_target_mux (
  input  fetch_pkg::redirect_t redirect_i,
  input  fetch_pkg::targets_t  targets_i,
  input  fetch_pkg::trap_cfg_t trap_cfg_i,
  input  logic [31:0]          pc_id_i,        // pc of instruction in id
  output logic [31:0]          fetch_addr_n_o
);

  logic [23:0] trap_base;   // mtvec or utvec base
  logic [5:0]  exc_vec;     // irq cause of the selected mode
  logic [31:0] exc_pc;

  //////////////////////////////
  // trap entry
  //////////////////////////////

  always_comb begin
    if (redirect_i.trap_sel == fetch_pkg::TRAP_USER) begin
      trap_base = trap_cfg_i.u_base;
      exc_vec   = redirect_i.u_vec;
    end else begin
      trap_base = trap_cfg_i.m_base;  // machine for anything else
      exc_vec   = redirect_i.m_vec;
    end

    case (redirect_i.exc_pc_mux)
      fetch_pkg::EXC_PC_EXCEPTION: exc_pc = {trap_base, 8'h00};  // all exceptions at base
      // base msb falls off the 32-bit address here
      fetch_pkg::EXC_PC_IRQ:       exc_pc = {trap_base[22:0], 1'b0, exc_vec, 2'b00};
      fetch_pkg::EXC_PC_DBG:       exc_pc = {trap_cfg_i.dm_halt, 2'b00};
      default:                     exc_pc = {trap_base, 8'h00};
    endcase
  end

  //////////////////////////////
  // next fetch address
  //////////////////////////////

  always_comb begin
    unique case (redirect_i.pc_mux)
      fetch_pkg::PC_BOOT:      fetch_addr_n_o = {targets_i.boot, 1'b0};
      fetch_pkg::PC_JUMP:      fetch_addr_n_o = targets_i.jump_id;
      fetch_pkg::PC_BRANCH:    fetch_addr_n_o = targets_i.jump_ex;
      fetch_pkg::PC_EXCEPTION: fetch_addr_n_o = exc_pc;
      fetch_pkg::PC_MRET:      fetch_addr_n_o = targets_i.mepc;   // back from m trap
      fetch_pkg::PC_URET:      fetch_addr_n_o = targets_i.uepc;
      fetch_pkg::PC_DRET:      fetch_addr_n_o = targets_i.depc;   // leave debug mode
      fetch_pkg::PC_FENCEI:    fetch_addr_n_o = pc_id_i + 32'd4;  // reload after fence.i
      default:                 fetch_addr_n_o = {targets_i.boot, 1'b0};
    endcase
  end

endmodule

// File: hw/prefetch_buffer.sv
// word prefetch queue with request issue, in-order response tracking and flush on branch
`timescale 1ns/1ps

module prefetch_buffer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_i,          // fetch enable
  input  logic                 branch_i,       // flush and restart
  input  logic [31:0]          branch_addr_i,
  input  logic                 fetch_ready_i,
  output logic                 fetch_valid_o,
  output logic [31:0]          fetch_rdata_o,
  output logic [31:0]          fetch_addr_o,
  output fetch_pkg::ibus_req_t ibus_req_o,
  input  fetch_pkg::ibus_rsp_t ibus_rsp_i
);

  logic [1:0]  cnt_q, cnt_n;          // words in queue
  logic [1:0]  out_q, out_n;          // live requests still waiting for rvalid
  logic [1:0]  disc_q, disc_n;        // responses of a flushed stream
  logic [31:0] fetch_addr_q, fetch_addr_n;  // next address to request
  logic [31:0] rsp_addr_q, rsp_addr_n;      // address of next live response
  logic [31:0] q_data [2];            // entry 0 is the head
  logic [31:0] q_addr [2];
  logic [1:0]  pending;
  logic        grant, pop;
  logic        rsp_live, rsp_drop;
  logic        wr_idx;

  //////////////////////////////
  // bus side
  //////////////////////////////

  // a branch empties the queue in the same cycle
  assign pending = (branch_i ? 2'd0 : cnt_q) + out_q + disc_q;

  assign ibus_req_o.req  = req_i & (pending < 2'(fetch_pkg::FIFO_DEPTH));
  assign ibus_req_o.addr = branch_i ? branch_addr_i : fetch_addr_q;  // new stream at once

  assign grant    = ibus_req_o.req & ibus_rsp_i.gnt;
  assign rsp_drop = ibus_rsp_i.rvalid & (branch_i | (disc_q != 2'd0));  // old stream
  assign rsp_live = ibus_rsp_i.rvalid & ~rsp_drop;

  // queue side
  assign pop    = fetch_ready_i & (cnt_q != 2'd0) & ~branch_i;
  assign wr_idx = cnt_q[1] | (cnt_q[0] & ~pop);  // slot after this cycle's pop

  always_comb begin
    if (branch_i) begin
      cnt_n        = 2'd0;
      out_n        = {1'b0, grant};                     // only the new request is live
      disc_n       = disc_q + out_q - {1'b0, rsp_drop}; // everything older gets dropped
      fetch_addr_n = grant ? branch_addr_i + 32'd4 : branch_addr_i;
      rsp_addr_n   = branch_addr_i;
    end else begin
      cnt_n        = cnt_q - {1'b0, pop} + {1'b0, rsp_live};
      out_n        = out_q + {1'b0, grant} - {1'b0, rsp_live};
      disc_n       = disc_q - {1'b0, rsp_drop};
      fetch_addr_n = grant ? fetch_addr_q + 32'd4 : fetch_addr_q;  // word step per grant
      rsp_addr_n   = rsp_live ? rsp_addr_q + 32'd4 : rsp_addr_q;
    end
  end

  //////////////////////////////
  // state
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q        <= 2'd0;
      out_q        <= 2'd0;
      disc_q       <= 2'd0;
      fetch_addr_q <= '0;
      rsp_addr_q   <= '0;
    end else begin
      cnt_q        <= cnt_n;
      out_q        <= out_n;
      disc_q       <= disc_n;
      fetch_addr_q <= fetch_addr_n;
      rsp_addr_q   <= rsp_addr_n;
    end
  end

  // shift on pop, later write wins on the same slot
  always_ff @(posedge clk) begin
    if (pop) begin
      q_data[0] <= q_data[1];
      q_addr[0] <= q_addr[1];
    end
    if (rsp_live) begin
      q_data[wr_idx] <= ibus_rsp_i.rdata;
      q_addr[wr_idx] <= rsp_addr_q;
    end
  end

  assign fetch_valid_o = (cnt_q != 2'd0);
  assign fetch_rdata_o = q_data[0];
  assign fetch_addr_o  = q_addr[0];

endmodule

// File: hw/rvc_pkg.sv
// rv32 opcode and funct3 constants, compressed subset encodings and the fetched word union
package rvc_pkg;

  //////////////////////////////
  // 32-bit encodings
  //////////////////////////////

  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_OP     = 7'h33;

  localparam logic [2:0] F3_ADD  = 3'b000;  // add and addi
  localparam logic [2:0] F3_WORD = 3'b010;  // lw and sw

  //////////////////////////////
  // compressed encodings
  //////////////////////////////

  localparam logic [1:0] Q0 = 2'b00;
  localparam logic [1:0] Q1 = 2'b01;
  localparam logic [1:0] Q2 = 2'b10;
  localparam logic [1:0] Q3 = 2'b11;        // not compressed

  localparam logic [2:0] C_F3_LW     = 3'b010;  // q0
  localparam logic [2:0] C_F3_SW     = 3'b110;  // q0
  localparam logic [2:0] C_F3_ADDI   = 3'b000;  // q1
  localparam logic [2:0] C_F3_LI     = 3'b010;  // q1
  localparam logic [2:0] C_F3_J      = 3'b101;  // q1
  localparam logic [2:0] C_F3_MV_ADD = 3'b100;  // q2, bit 12 picks add

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } full_instr_t;

  typedef struct packed {
    logic [15:0] upper;     // second halfword, not fetched from
    logic [2:0]  funct3;
    logic        b12;
    logic [4:0]  rd_rs1;
    logic [4:0]  rs2;
    logic [1:0]  quadrant;
  } comp_pair_t;

  // low two bits tell which view is live
  typedef union packed {
    full_instr_t full;
    comp_pair_t  comp;
  } fetch_word_u;

endpackage

// File: list.f
hw/fetch_pkg.sv
hw/rvc_pkg.sv
hw/pc_target_mux.sv
hw/prefetch_buffer.sv
hw/compressed_decoder.sv
hw/if_stage.sv
hw/fetch_top.sv
bench/tb_clock_gen.sv
bench/fetch_properties.sv
bench/tb_fetch.sv
